//--- flist.f
+incdir+dv
verilog/ofdm_rx_pkg.sv
verilog/axis_fifo.sv
verilog/cp_len_sched.sv
verilog/cp_removal.sv
verilog/ofdm_cp_strip.sv
dv/tb_ofdm_cp_strip.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cyclic prefix strip testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_ofdm_cp_strip -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- dv/cp_strip_vectors.svh
`ifndef CP_STRIP_VECTORS_SVH
`define CP_STRIP_VECTORS_SVH

// Row fields are symbol length, long prefix, short prefix, symbol count
// and sink stall percent
// Each row is one run phase with its own reset

localparam int NUM_PHASES = 5;

phase_row_t phase_tab [NUM_PHASES] = '{
  // Sink always ready, 16 symbols cross one slot boundary
  '{80, 20, 16, 16,  0},

  // Zero prefix, whole symbols pass unchanged
  '{64,  0,  0,  4, 25},

  // Heavy sink stalls, slot starts at symbols 0, 14 and 28
  '{72, 24,  8, 30, 75},

  // Long prefix leaves a body of one sample
  '{20, 19,  1, 15, 50},

  // Two full slots with moderate stalls
  '{40, 10,  4, 28, 40}
};

`endif

//--- dv/tb_ofdm_cp_strip.sv
`timescale 1ns/1ps

module tb_ofdm_cp_strip
  import ofdm_rx_pkg::*;
();

  // One run phase of the stimulus table
  typedef struct packed {
    int sym_len;
    int cp_long;
    int cp_short;
    int n_syms;
    int stall_pct;
  } phase_row_t;

  `include "cp_strip_vectors.svh"

  // Idle cycles checked after reset and after each phase
  localparam int IDLE_CHECK = 2;
  localparam int DRAIN_CYCLES = 16;

  logic              clk = 1'b0;
  logic              rst;
  cp_len_t           i_cp_long;
  cp_len_t           i_cp_short;
  logic [DATA_W-1:0] i_data;
  logic              i_last;
  logic              i_valid;
  logic              o_ready;
  logic [DATA_W-1:0] o_data;
  logic              o_last;
  logic              o_valid;
  logic              i_ready;

  // Expected body samples, flags and body lengths per symbol
  logic [DATA_W-1:0] exp_data_q [$];
  logic              exp_last_q [$];
  int                exp_len_q [$];

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          out_cnt;
  int          out_sym;
  logic [31:0] rng_state;

  ofdm_cp_strip dut_i (
    .clk(clk), .rst(rst),
    .i_cp_long(i_cp_long), .i_cp_short(i_cp_short),
    .i_data(i_data), .i_last(i_last), .i_valid(i_valid), .o_ready(o_ready),
    .o_data(o_data), .o_last(o_last), .o_valid(o_valid), .i_ready(i_ready)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // Run limit, scaled by the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random sink ready, low with the given percent chance
  function automatic logic next_sink_ready(input int stall_pct);
    rng_state = xorshift32(rng_state);
    return (rng_state % 32'd100) >= 32'(stall_pct);
  endfunction

  // Slot rule, symbol 0 of every 14 takes the long prefix
  function automatic int prefix_for_symbol(input int sym, input int cp_long,
                                           input int cp_short);
    return ((sym % SYMS_PER_SLOT) == 0) ? cp_long : cp_short;
  endfunction

  // Phase in the top byte, then symbol number, then sample index
  function automatic logic [DATA_W-1:0] sample_value(input int p, input int sym,
                                                      input int idx);
    return {8'(p), 12'(sym), 12'(idx)};
  endfunction

  function automatic int total_table_samples();
    int sum;
    sum = 0;
    for (int r = 0; r < NUM_PHASES; r++) begin
      sum += phase_tab[r].sym_len * phase_tab[r].n_syms;
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Queue every body sample the phase should produce
  task automatic build_expected(input int p, input phase_row_t row);
    int cp;
    for (int s = 0; s < row.n_syms; s++) begin
      cp = prefix_for_symbol(s, row.cp_long, row.cp_short);
      exp_len_q.push_back(row.sym_len - cp);
      for (int i = cp; i < row.sym_len; i++) begin
        exp_data_q.push_back(sample_value(p, s, i));
        exp_last_q.push_back(i == row.sym_len - 1);
      end
    end
  endtask

  // Compare one accepted output beat with the head of the queues
  task automatic check_output_beat(input phase_row_t row);
    logic [DATA_W-1:0] exp_d;
    logic              exp_l;
    int                exp_len;
    checks++;
    assert (exp_data_q.size() != 0) else begin
      $display("** Error at time %0t: output beat %0h with no sample expected", $time,
               o_data);
      errors++;
    end
    if (exp_data_q.size() != 0) begin
      exp_d = exp_data_q.pop_front();
      exp_l = exp_last_q.pop_front();
      // First body sample sits right after the prefix
      if (out_cnt == 0) begin
        check_value("first sample index", 32'(o_data[11:0]),
                    32'(prefix_for_symbol(out_sym, row.cp_long, row.cp_short)));
      end
      check_value("o_data", o_data, exp_d);
      check_value("o_last", 32'(o_last), 32'(exp_l));
      out_cnt++;
      if (o_last && exp_len_q.size() != 0) begin
        exp_len = exp_len_q.pop_front();
        check_value("body length", 32'(out_cnt), 32'(exp_len));
        out_cnt = 0;
        out_sym++;
      end
    end
  endtask

  // Source beat for the current position, sink ready from the generator
  task automatic drive_inputs(input int p, input phase_row_t row, input bit done,
                              input int sym, input int idx);
    if (!done) begin
      i_valid <= 1'b1;
      i_data  <= sample_value(p, sym, idx);
      i_last  <= (idx == row.sym_len - 1);
    end else begin
      i_valid <= 1'b0;
      i_last  <= 1'b0;
    end
    i_ready <= next_sink_ready(row.stall_pct);
  endtask

  task automatic run_phase(input int p);
    phase_row_t row;
    int         src_sym;
    int         src_idx;
    bit         src_done;
    row = phase_tab[p];

    // Prefix settings change only under reset
    @(posedge clk);
    rst        <= 1'b1;
    i_valid    <= 1'b0;
    i_last     <= 1'b0;
    i_data     <= '0;
    i_ready    <= 1'b0;
    i_cp_long  <= cp_len_t'(row.cp_long);
    i_cp_short <= cp_len_t'(row.cp_short);
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Output stays quiet until samples arrive, prefix removal idles with ready low
    repeat (IDLE_CHECK) begin
      @(posedge clk);
      check_value("o_valid after reset", 32'(o_valid), 32'd0);
      check_value("o_ready while idle", 32'(o_ready), 32'd0);
    end

    build_expected(p, row);
    out_cnt  = 0;
    out_sym  = 0;
    src_sym  = 0;
    src_idx  = 0;
    src_done = (row.n_syms == 0);
    drive_inputs(p, row, src_done, src_sym, src_idx);

    while (!src_done || exp_data_q.size() != 0) begin
      @(posedge clk);
      // Handshakes as seen by the DUT at this edge
      if (o_valid && i_ready) begin
        check_output_beat(row);
      end
      if (i_valid && o_ready) begin
        src_idx++;
        if (src_idx == row.sym_len) begin
          src_idx = 0;
          src_sym++;
          src_done = (src_sym == row.n_syms);
        end
      end
      drive_inputs(p, row, src_done, src_sym, src_idx);
    end

    // No extra beats once every body sample is out
    i_ready <= 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      check_value("o_valid after drain", 32'(o_valid), 32'd0);
      check_value("o_ready after drain", 32'(o_ready), 32'd0);
    end
    check_value("symbols out", 32'(out_sym), 32'(row.n_syms));
  endtask

  initial begin
    rst        = 1'b1;
    i_cp_long  = '0;
    i_cp_short = '0;
    i_data     = '0;
    i_last     = 1'b0;
    i_valid    = 1'b0;
    i_ready    = 1'b0;
    rng_state  = 32'd42926;
    cycle_limit = 4 * total_table_samples() + 200;

    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(p);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_ofdm_cp_strip

//--- verilog/ofdm_cp_strip.sv
`timescale 1ns/1ps

module ofdm_cp_strip
  import ofdm_rx_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // Prefix settings
  input  cp_len_t           i_cp_long,
  input  cp_len_t           i_cp_short,

  // Received samples, one packet per symbol
  input  logic [DATA_W-1:0] i_data,
  input  logic              i_last,
  input  logic              i_valid,
  output logic              o_ready,

  // Stripped symbol bodies
  output logic [DATA_W-1:0] o_data,
  output logic              o_last,
  output logic              o_valid,
  input  logic              i_ready
);

  // Scheduler to length queue
  cp_len_t      sched_len;
  logic         sched_valid;
  logic         sched_ready;

  // Length queue to prefix removal
  cp_len_t      q_len;
  logic         q_valid;
  logic         q_ready;

  // Sample beats around prefix removal
  sample_beat_t in_beat;
  sample_beat_t strip_beat;
  logic         strip_valid;
  logic         strip_ready;
  sample_beat_t out_beat;

  // Pack input sample and flag
  assign in_beat.data = i_data;
  assign in_beat.last = i_last;

  cp_len_sched cp_len_sched_i (
    .clk(clk), .rst(rst),
    .i_cp_long(i_cp_long), .i_cp_short(i_cp_short),
    .o_cp_len(sched_len), .o_cp_valid(sched_valid), .i_cp_ready(sched_ready)
  );

  axis_fifo #(.DEPTH(CP_FIFO_DEPTH), .T(cp_len_t)) cp_len_q (
    .clk(clk), .rst(rst),
    .i_data(sched_len), .i_valid(sched_valid), .o_ready(sched_ready),
    .o_data(q_len), .o_valid(q_valid), .i_ready(q_ready)
  );

  cp_removal cp_removal_i (
    .clk(clk), .rst(rst),
    .i_cp_len(q_len), .i_cp_valid(q_valid), .o_cp_ready(q_ready),
    .i_data(in_beat), .i_valid(i_valid), .o_ready(o_ready),
    .o_data(strip_beat), .o_valid(strip_valid), .i_ready(strip_ready)
  );

  axis_fifo #(.DEPTH(OUT_FIFO_DEPTH), .T(sample_beat_t)) out_q (
    .clk(clk), .rst(rst),
    .i_data(strip_beat), .i_valid(strip_valid), .o_ready(strip_ready),
    .o_data(out_beat), .o_valid(o_valid), .i_ready(i_ready)
  );

  // Unpack output beat
  assign o_data = out_beat.data;
  assign o_last = out_beat.last;

endmodule : ofdm_cp_strip

//--- verilog/cp_removal.sv
`timescale 1ns/1ps

module cp_removal
  import ofdm_rx_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // Prefix length for the next symbol
  input  cp_len_t      i_cp_len,
  input  logic         i_cp_valid,
  output logic         o_cp_ready,

  // Received symbol stream, prefix included
  input  sample_beat_t i_data,
  input  logic         i_valid,
  output logic         o_ready,

  // Symbol bodies, one packet per symbol
  output sample_beat_t o_data,
  output logic         o_valid,
  input  logic         i_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREFIX,
    ST_BODY
  } state_t;

  state_t            state;
  cp_len_t           cp_len_reg;
  logic [CNT_W-1:0]  count;
  logic              in_xfer;

  assign in_xfer = i_valid && o_ready;

  always_ff @(posedge clk) begin
    // Length ready is a one-cycle pulse
    o_cp_ready <= 1'b0;

    case (state)
      // Wait for a symbol and its length, this is the bubble cycle
      ST_IDLE: begin
        count      <= CNT_W'(1);
        cp_len_reg <= i_cp_len;
        if (i_valid && i_cp_valid) begin
          o_cp_ready <= 1'b1;
          if (i_cp_len != '0) begin
            state <= ST_PREFIX;
          end else begin
            state <= ST_BODY;
          end
        end
      end

      // Discard prefix samples
      ST_PREFIX: begin
        if (in_xfer) begin
          count <= count + 1'b1;
          if (count == CNT_W'(cp_len_reg)) begin
            state <= ST_BODY;
          end
        end
      end

      // Forward up to and including the last sample
      ST_BODY: begin
        if (in_xfer && i_data.last) begin
          state <= ST_IDLE;
        end
      end

      default: begin
        state <= ST_IDLE;
      end
    endcase

    if (rst) begin
      state      <= ST_IDLE;
      o_cp_ready <= 1'b0;
    end
  end

  // Body samples pass through combinationally
  assign o_data  = i_data;
  assign o_valid = (state == ST_BODY) ? i_valid : 1'b0;

  // Prefix drains at full rate, body follows the sink
  assign o_ready = (state == ST_BODY)   ? i_ready :
                   (state == ST_PREFIX) ? 1'b1    : 1'b0;

  a_state_legal : assert property (@(posedge clk) disable iff (rst)
    state inside {ST_IDLE, ST_PREFIX, ST_BODY});

  // Prefix longer than the symbol
  a_no_last_in_prefix : assert property (@(posedge clk) disable iff (rst)
    (state == ST_PREFIX && i_valid) |-> !i_data.last);

  // Length still offered when the ready pulse arrives
  a_len_on_ready : assert property (@(posedge clk) disable iff (rst)
    o_cp_ready |-> i_cp_valid);

endmodule : cp_removal

//--- verilog/cp_len_sched.sv
`timescale 1ns/1ps

module cp_len_sched
  import ofdm_rx_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Prefix settings, static outside reset
  input  cp_len_t i_cp_long,
  input  cp_len_t i_cp_short,

  // One length per symbol
  output cp_len_t o_cp_len,
  output logic    o_cp_valid,
  input  logic    i_cp_ready
);

  // Position of the next symbol within the slot
  logic [SYM_IDX_W-1:0] sym_idx;
  logic                 cp_accept;

  assign cp_accept = o_cp_valid && i_cp_ready;

  // Advance on each accepted length, wrap at slot end
  always_ff @(posedge clk) begin
    if (rst) begin
      sym_idx <= '0;
    end else if (cp_accept) begin
      if (sym_idx == SYM_IDX_W'(SYMS_PER_SLOT - 1)) begin
        sym_idx <= '0;
      end else begin
        sym_idx <= sym_idx + 1'b1;
      end
    end
  end

  // Valid is low for one cycle after reset and after each accept
  always_ff @(posedge clk) begin
    if (rst) begin
      o_cp_valid <= 1'b0;
    end else begin
      o_cp_valid <= !cp_accept;
    end
  end

  // Length is loaded in the gap cycle from the updated index
  always_ff @(posedge clk) begin
    if (!o_cp_valid) begin
      o_cp_len <= (sym_idx == '0) ? i_cp_long : i_cp_short;
    end
  end

  // Index range
  a_idx_range : assert property (@(posedge clk) disable iff (rst)
    sym_idx < SYM_IDX_W'(SYMS_PER_SLOT));

endmodule : cp_len_sched

//--- verilog/axis_fifo.sv
`timescale 1ns/1ps

module axis_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic [7:0]
) (
  input  logic clk,
  input  logic rst,

  // Write side
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,

  // Read side
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  // Pointer and occupancy widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  // Circular storage
  T mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Transfers on each side
  assign wr_en = i_valid && o_ready;
  assign rd_en = o_valid && i_ready;

  // Full and empty come straight from the occupancy count
  assign o_ready = (count != OCC_W'(DEPTH));
  assign o_valid = (count != '0);

  // Head of the queue
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap at DEPTH, count tracks the difference
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy bound
  a_count_max : assert property (@(posedge clk) disable iff (rst)
    count <= OCC_W'(DEPTH));

  // Head beat holds while the reader stalls
  a_hold_stalled : assert property (@(posedge clk) disable iff (rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule : axis_fifo

//--- verilog/ofdm_rx_pkg.sv
package ofdm_rx_pkg;

  // Sample width, 16-bit I and 16-bit Q
  localparam int DATA_W = 32;

  // Prefix length width, prefixes up to 4095 samples
  localparam int CP_LEN_W = 12;

  // Symbol length width
  localparam int SYM_LEN_W = 17;

  // Counter width covers both prefix and symbol lengths
  localparam int CNT_W = (SYM_LEN_W > CP_LEN_W) ? SYM_LEN_W : CP_LEN_W;

  // Slot structure, symbol 0 carries the long prefix
  localparam int SYMS_PER_SLOT = 14;
  localparam int SYM_IDX_W     = $clog2(SYMS_PER_SLOT);

  // Queue depths
  localparam int CP_FIFO_DEPTH  = 4;
  localparam int OUT_FIFO_DEPTH = 16;

  // One prefix length
  typedef logic [CP_LEN_W-1:0] cp_len_t;

  // One sample beat with its end of symbol flag
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } sample_beat_t;

endpackage : ofdm_rx_pkg
